// ==== camera_cfg.svh ====
// ====================
// Pixel path size settings
// Sample, coordinate, component and word widths,
// line buffer depth, frame-rate window
// ====================
`ifndef CAMERA_CFG_SVH
`define CAMERA_CFG_SVH

// Sensor side
`define RAW_WIDTH 12           // Sensor sample bits
`define COORD_WIDTH 12         // Column, row and frame sizes

// Colour side
`define COMP_WIDTH 8           // Component bits fed to the hue stage
`define HUE_WIDTH 8            // Hue result bits
`define PACK_BITS 5            // Bits per component in an RGB word
`define WORD_WIDTH 16          // Buffer word

// Line buffer holds one even Bayer row
`define MAX_LINE_WIDTH 64

// Rate window, counted in pixel clocks
`define RATE_WINDOW_CYCLES 256

`endif

// ==== camera_pkg.sv ====
// ====================
// Sensor-side types
// Raw samples, coordinates, frame counts
// ====================
`default_nettype none

`include "camera_cfg.svh"

package camera_pkg;

  // One sensor sample as seen on the pins
  typedef logic [`RAW_WIDTH-1:0] raw_sample_t;

  // Column, row, width or height
  typedef logic [`COORD_WIDTH-1:0] coord_t;

  // Captured frames, also the frames-per-window rate
  typedef logic [31:0] frame_count_t;

endpackage

`default_nettype wire

// ==== pixel_pkg.sv ====
// ====================
// Colour-side types
// Components, hue, buffer words, hue sectors
// ====================
`default_nettype none

`include "camera_cfg.svh"

package pixel_pkg;

  // ====================
  // Types
  // ====================
  typedef logic [`RAW_WIDTH-1:0]  component_t;    // Full-precision colour
  typedef logic [`COMP_WIDTH-1:0] hue_comp_t;     // Truncated for hue math
  typedef logic [`HUE_WIDTH-1:0]  hue_t;
  typedef logic [`WORD_WIDTH-1:0] buffer_word_t;  // Packed output word

  // ====================
  // Hue sectors
  // ====================
  // Circle of 256 split in three, one sector per dominant colour
  localparam hue_t SECTOR_RED_BASE   = hue_t'(0);
  localparam hue_t SECTOR_GREEN_BASE = hue_t'(85);
  localparam hue_t SECTOR_BLUE_BASE  = hue_t'(171);
  localparam hue_t SECTOR_SPAN       = hue_t'(43);   // Half a sector width

endpackage

`default_nettype wire

// ==== ccd_capture.sv ====
// ====================
// Sensor pin registers and per-frame capture gating
// Column and row counters, captured frame counter
// ====================
`timescale 1ns/10ps
`default_nettype none

module ccd_capture (
  input  wire logic                    ccd_pixel_clk,
  input  wire logic                    reset,
  input  wire camera_pkg::raw_sample_t sensor_data,
  input  wire logic                    frame_valid,
  input  wire logic                    line_valid,
  input  wire logic                    capture_enable,
  input  wire camera_pkg::coord_t      frame_width,
  output camera_pkg::raw_sample_t      sample,
  output logic                         sample_valid,
  output camera_pkg::coord_t           column,
  output camera_pkg::coord_t           row,
  output camera_pkg::frame_count_t     frame_count
);
  import camera_pkg::*;

  raw_sample_t data_q;                  // Registered pins
  logic        fval_q, lval_q;
  logic        fval_d;                  // Previous fval_q, edge detect
  logic        capture_on;              // Current frame accepted
  coord_t      col_count, row_count;    // Position of the next sample
  logic        frame_start, frame_end;
  logic        capture_now, take_sample;
  coord_t      cur_col, cur_row;
  logic        col_wrap;

  // ====================
  // Pin registers
  // ====================
  always_ff @(posedge ccd_pixel_clk) begin
    data_q <= sensor_data;
    if (reset) begin
      fval_q <= 1'b0;
      lval_q <= 1'b0;
      fval_d <= 1'b0;
    end else begin
      fval_q <= frame_valid;
      lval_q <= line_valid;
      fval_d <= fval_q;
    end
  end

  assign frame_start = fval_q & ~fval_d;
  assign frame_end   = ~fval_q & fval_d;
  // Start switch only sampled as the frame opens
  assign capture_now = frame_start ? capture_enable : capture_on;
  assign take_sample = fval_q & lval_q & capture_now;
  assign cur_col     = frame_start ? '0 : col_count;   // First sample may land on the start
  assign cur_row     = frame_start ? '0 : row_count;
  assign col_wrap    = (cur_col == frame_width - 1'b1);

  // ====================
  // Gating and counters
  // ====================
  always_ff @(posedge ccd_pixel_clk) begin
    if (reset) begin
      capture_on   <= 1'b0;
      sample_valid <= 1'b0;
      col_count    <= '0;
      row_count    <= '0;
      column       <= '0;
      row          <= '0;
      frame_count  <= '0;
    end else begin
      sample_valid <= take_sample;
      if (frame_start) begin
        capture_on <= capture_enable;
        col_count  <= '0;
        row_count  <= '0;
      end
      if (take_sample) begin
        column    <= cur_col;                          // Travels with the sample
        row       <= cur_row;
        col_count <= col_wrap ? '0 : cur_col + 1'b1;
        row_count <= col_wrap ? cur_row + 1'b1 : cur_row;
      end
      if (frame_end && capture_on)
        frame_count <= frame_count + 1'b1;             // Only frames we took
    end
  end

  // Sample payload, second edge
  always_ff @(posedge ccd_pixel_clk) begin
    if (take_sample)
      sample <= data_q;
  end

endmodule

`default_nettype wire

// ==== bayer_demosaic.sv ====
// ====================
// Bayer quad to RGB reconstruction
// One line buffer for the even row
// ====================
`timescale 1ns/10ps
`default_nettype none

`include "camera_cfg.svh"

module bayer_demosaic (
  input  wire logic                    ccd_pixel_clk,
  input  wire logic                    reset,
  input  wire camera_pkg::raw_sample_t sample,
  input  wire logic                    sample_valid,
  input  wire camera_pkg::coord_t      column,
  input  wire camera_pkg::coord_t      row,
  output pixel_pkg::component_t        red,
  output pixel_pkg::component_t        green,
  output pixel_pkg::component_t        blue,
  output logic                         rgb_valid
);
  import camera_pkg::*;
  import pixel_pkg::*;

  localparam int ADDR_W = $clog2(`MAX_LINE_WIDTH);

  // Quad layout
  //   even row  G R
  //   odd row   B G
  raw_sample_t         line_buf [`MAX_LINE_WIDTH];  // Even row, G and R
  raw_sample_t         prev_sample;                 // Left neighbour, B on odd rows
  logic [ADDR_W-1:0]   col_addr;
  logic [ADDR_W-1:0]   pair_addr;                   // Even column of the quad
  logic                even_row;
  logic                quad_done;
  logic [`RAW_WIDTH:0] green_sum;                   // One spare bit for the carry

  assign col_addr  = column[ADDR_W-1:0];
  assign pair_addr = {col_addr[ADDR_W-1:1], 1'b0};
  assign even_row  = ~row[0];
  assign quad_done = sample_valid & row[0] & column[0];  // Bottom-right G closes the quad

  // Upper G from the buffer, lower G is the live sample
  assign green_sum = {1'b0, line_buf[pair_addr]} + {1'b0, sample};

  // ====================
  // Line buffer
  // ====================
  always_ff @(posedge ccd_pixel_clk) begin
    if (sample_valid && even_row)
      line_buf[col_addr] <= sample;
  end

  always_ff @(posedge ccd_pixel_clk) begin
    if (sample_valid)
      prev_sample <= sample;
  end

  // ====================
  // Pixel output
  // ====================
  always_ff @(posedge ccd_pixel_clk) begin
    if (quad_done) begin
      red   <= line_buf[col_addr];                   // R sits above current G
      blue  <= prev_sample;
      green <= green_sum[`RAW_WIDTH:1];              // Truncated average
    end
  end

  always_ff @(posedge ccd_pixel_clk) begin
    if (reset)
      rgb_valid <= 1'b0;
    else
      rgb_valid <= quad_done;                        // One pixel per quad
  end

endmodule

`default_nettype wire

// ==== rgb_to_hue.sv ====
// ====================
// RGB to hue, three-stage pipeline
// Extremes, scaled division, sector base
// ====================
`timescale 1ns/10ps
`default_nettype none

`include "camera_cfg.svh"

module rgb_to_hue (
  input  wire logic                  ccd_pixel_clk,
  input  wire logic                  reset,
  input  wire pixel_pkg::component_t red,
  input  wire pixel_pkg::component_t green,
  input  wire pixel_pkg::component_t blue,
  input  wire logic                  rgb_valid,
  output pixel_pkg::hue_t            hue,
  output logic                       hue_valid
);
  import pixel_pkg::*;

  localparam int PROD_W = 2 * `COMP_WIDTH;   // Span times difference fits here

  hue_comp_t                     r8, g8, b8;
  hue_comp_t                     c_max, c_min;
  logic signed [`COMP_WIDTH:0]   c_num;      // Signed difference, one extra bit
  hue_t                          c_base;
  logic                          s1_valid, s2_valid;
  hue_comp_t                     s1_delta;
  logic signed [`COMP_WIDTH:0]   s1_num;
  hue_t                          s1_base, s2_base, s2_quot;
  logic signed [PROD_W-1:0]      span_ext, num_ext, delta_ext;
  logic signed [PROD_W-1:0]      scaled_num, div_num;

  // Top bits only
  assign r8 = red[`RAW_WIDTH-1 -: `COMP_WIDTH];
  assign g8 = green[`RAW_WIDTH-1 -: `COMP_WIDTH];
  assign b8 = blue[`RAW_WIDTH-1 -: `COMP_WIDTH];

  // ====================
  // Stage 1, extremes and sector
  // ====================
  always_comb begin
    if (r8 >= g8 && r8 >= b8) begin            // Red wins ties
      c_max  = r8;
      c_num  = $signed({1'b0, g8}) - $signed({1'b0, b8});
      c_base = SECTOR_RED_BASE;
    end else if (g8 >= b8) begin               // Then green
      c_max  = g8;
      c_num  = $signed({1'b0, b8}) - $signed({1'b0, r8});
      c_base = SECTOR_GREEN_BASE;
    end else begin
      c_max  = b8;
      c_num  = $signed({1'b0, r8}) - $signed({1'b0, g8});
      c_base = SECTOR_BLUE_BASE;
    end
    if (r8 <= g8 && r8 <= b8)
      c_min = r8;
    else
      c_min = (g8 <= b8) ? g8 : b8;
  end

  always_ff @(posedge ccd_pixel_clk) begin
    s1_delta <= c_max - c_min;
    s1_num   <= c_num;
    s1_base  <= c_base;
  end

  // ====================
  // Stage 2, scaled division
  // ====================
  assign span_ext   = $signed({{(PROD_W-`HUE_WIDTH){1'b0}}, SECTOR_SPAN});
  assign num_ext    = {{(PROD_W-`COMP_WIDTH-1){s1_num[`COMP_WIDTH]}}, s1_num};
  assign delta_ext  = $signed({{(PROD_W-`COMP_WIDTH){1'b0}}, s1_delta});
  assign scaled_num = span_ext * num_ext;
  // Grey pixel, no hue; signed divide truncates toward zero
  assign div_num    = (s1_delta == '0) ? $signed(PROD_W'(0)) : scaled_num / delta_ext;

  always_ff @(posedge ccd_pixel_clk) begin
    s2_quot <= div_num[`HUE_WIDTH-1:0];      // Within +-SPAN, low bits enough
    s2_base <= s1_base;
  end

  // ====================
  // Stage 3, base plus offset, wraps mod 256
  // ====================
  always_ff @(posedge ccd_pixel_clk) begin
    hue <= s2_base + s2_quot;
  end

  // Strobe follows the data through all three stages
  always_ff @(posedge ccd_pixel_clk) begin
    if (reset) begin
      s1_valid  <= 1'b0;
      s2_valid  <= 1'b0;
      hue_valid <= 1'b0;
    end else begin
      s1_valid  <= rgb_valid;
      s2_valid  <= s1_valid;
      hue_valid <= s2_valid;
    end
  end

endmodule

`default_nettype wire

// ==== pixel_packer.sv ====
// ====================
// Buffer word packer, RGB555 or hue
// ====================
`timescale 1ns/10ps
`default_nettype none

`include "camera_cfg.svh"

module pixel_packer (
  input  wire logic                  ccd_pixel_clk,
  input  wire logic                  reset,
  input  wire logic                  rgb_mode,
  input  wire pixel_pkg::component_t red,
  input  wire pixel_pkg::component_t green,
  input  wire pixel_pkg::component_t blue,
  input  wire logic                  rgb_valid,
  input  wire pixel_pkg::hue_t       hue,
  input  wire logic                  hue_valid,
  output pixel_pkg::buffer_word_t    pixel_word,
  output logic                       word_valid
);
  import pixel_pkg::*;

  buffer_word_t next_word;
  logic         next_valid;

  // Mode picks the stream, the other one is ignored
  assign next_word  = rgb_mode ?
                      {1'b0, red[`RAW_WIDTH-1 -: `PACK_BITS],
                       green[`RAW_WIDTH-1 -: `PACK_BITS],
                       blue[`RAW_WIDTH-1 -: `PACK_BITS]} :
                      {{(`WORD_WIDTH-`HUE_WIDTH){1'b0}}, hue};   // Hue in low byte
  assign next_valid = rgb_mode ? rgb_valid : hue_valid;

  always_ff @(posedge ccd_pixel_clk) begin
    if (next_valid)
      pixel_word <= next_word;                 // Held between strobes
  end

  always_ff @(posedge ccd_pixel_clk) begin
    if (reset)
      word_valid <= 1'b0;
    else
      word_valid <= next_valid;
  end

endmodule

`default_nettype wire

// ==== frame_rate_meter.sv ====
// ====================
// Frame rate over a fixed pixel-clock window
// ====================
`timescale 1ns/10ps
`default_nettype none

`include "camera_cfg.svh"

module frame_rate_meter (
  input  wire logic                     ccd_pixel_clk,
  input  wire logic                     reset,
  input  wire camera_pkg::frame_count_t frame_count,
  output camera_pkg::frame_count_t      frame_rate,
  output logic                          rate_pulse
);
  import camera_pkg::*;

  localparam int WIN_W = $clog2(`RATE_WINDOW_CYCLES);

  logic [WIN_W-1:0] win_count;        // Cycles into the current window
  frame_count_t     last_count;       // frame_count at the previous window end
  logic             win_end;

  assign win_end = (win_count == WIN_W'(`RATE_WINDOW_CYCLES - 1));

  always_ff @(posedge ccd_pixel_clk) begin
    if (reset) begin
      win_count  <= '0;
      last_count <= '0;
      frame_rate <= '0;
      rate_pulse <= 1'b0;
    end else if (win_end) begin
      win_count  <= '0;
      frame_rate <= frame_count - last_count;  // Frames seen this window
      last_count <= frame_count;
      rate_pulse <= ~rate_pulse;               // Toggles once per window
    end else begin
      win_count  <= win_count + 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== camera_pipeline_top.sv ====
// ====================
// Pixel path top level
// Capture, demosaic, hue, packer, rate meter
// ====================
`timescale 1ns/10ps
`default_nettype none

module camera_pipeline_top (
  input  wire logic                    ccd_pixel_clk,
  input  wire logic                    reset,
  input  wire camera_pkg::raw_sample_t sensor_data,
  input  wire logic                    frame_valid,
  input  wire logic                    line_valid,
  input  wire logic                    capture_enable,
  input  wire camera_pkg::coord_t      frame_width,
  input  wire camera_pkg::coord_t      frame_height,   // Kept for software, not consumed
  input  wire logic                    rgb_mode,
  output pixel_pkg::buffer_word_t      pixel_word,
  output logic                         word_valid,
  output camera_pkg::frame_count_t     frame_count,
  output camera_pkg::frame_count_t     frame_rate,
  output logic                         rate_pulse
);
  import camera_pkg::*;
  import pixel_pkg::*;

  // Capture to demosaic
  raw_sample_t sample;
  logic        sample_valid;
  coord_t      column, row;

  // Demosaic to hue and packer
  component_t  red, green, blue;
  logic        rgb_valid;

  // Hue to packer
  hue_t        hue;
  logic        hue_valid;

  ccd_capture u_capture (
    .ccd_pixel_clk (ccd_pixel_clk),
    .reset         (reset),
    .sensor_data   (sensor_data),
    .frame_valid   (frame_valid),
    .line_valid    (line_valid),
    .capture_enable(capture_enable),
    .frame_width   (frame_width),
    .sample        (sample),
    .sample_valid  (sample_valid),
    .column        (column),
    .row           (row),
    .frame_count   (frame_count)
  );

  bayer_demosaic u_demosaic (
    .ccd_pixel_clk (ccd_pixel_clk),
    .reset         (reset),
    .sample        (sample),
    .sample_valid  (sample_valid),
    .column        (column),
    .row           (row),
    .red           (red),
    .green         (green),
    .blue          (blue),
    .rgb_valid     (rgb_valid)
  );

  rgb_to_hue u_hue (
    .ccd_pixel_clk (ccd_pixel_clk),
    .reset         (reset),
    .red           (red),
    .green         (green),
    .blue          (blue),
    .rgb_valid     (rgb_valid),
    .hue           (hue),
    .hue_valid     (hue_valid)
  );

  pixel_packer u_packer (
    .ccd_pixel_clk (ccd_pixel_clk),
    .reset         (reset),
    .rgb_mode      (rgb_mode),
    .red           (red),
    .green         (green),
    .blue          (blue),
    .rgb_valid     (rgb_valid),
    .hue           (hue),
    .hue_valid     (hue_valid),
    .pixel_word    (pixel_word),
    .word_valid    (word_valid)
  );

  frame_rate_meter u_rate (
    .ccd_pixel_clk (ccd_pixel_clk),
    .reset         (reset),
    .frame_count   (frame_count),
    .frame_rate    (frame_rate),
    .rate_pulse    (rate_pulse)
  );

endmodule

`default_nettype wire

// ==== tb_checker.sv ====
// ====================
// Testbench checker
// Expected word queue, frame count and rate checks
// Per-test lines and the closing count line
// ====================
`timescale 1ns/10ps
`default_nettype none

module tb_checker (
  input  wire logic                     ccd_pixel_clk,
  input  wire logic                     reset,
  input  wire logic                     word_valid,
  input  wire pixel_pkg::buffer_word_t  pixel_word,
  input  wire camera_pkg::frame_count_t frame_count,
  input  wire camera_pkg::frame_count_t frame_rate,
  input  wire logic                     rate_pulse,
  input  wire logic                     exp_push,       // Queue one expected word
  input  wire pixel_pkg::buffer_word_t  exp_word,
  input  wire logic                     test_end,       // Current test is drained
  input  wire logic                     test_enabled,   // Test frame had capture on
  input  wire logic [127:0]             test_name,
  input  wire logic                     final_check,
  input  wire camera_pkg::frame_count_t enabled_frames,
  output int                            pending,
  output int                            error_count,
  output logic                          report_done
);
  import camera_pkg::*;
  import pixel_pkg::*;

  buffer_word_t exp_q[$];
  buffer_word_t exp_head;
  int           test_errors, tests_run, tests_failed, toggles;
  frame_count_t fc_mark;          // frame_count at the previous test end
  frame_count_t fc_prev;          // Value before the current edge
  frame_count_t fc_at_toggle;     // What the meter saw at its last window end
  frame_count_t rate_sum;
  logic         pulse_seen;

  // Record a failure against the running test
  task automatic note_error();
    error_count++;
    test_errors++;
  endtask

  // ====================
  // Sample at the falling edge, DUT outputs settled
  // ====================
  always @(negedge ccd_pixel_clk) begin
    if (reset) begin
      exp_q.delete();
      error_count  = 0;
      test_errors  = 0;
      tests_run    = 0;
      tests_failed = 0;
      toggles      = 0;
      fc_mark      = '0;
      fc_prev      = '0;
      fc_at_toggle = '0;
      rate_sum     = '0;
      pulse_seen   = 1'b0;
      report_done  = 1'b0;
    end else begin
      if (exp_push)
        exp_q.push_back(exp_word);
      if (word_valid) begin
        if (exp_q.size() == 0) begin
          $display("Unexpected word %h from the DUT in test %0s", pixel_word, test_name);
          note_error();
        end else begin
          exp_head = exp_q.pop_front();
          if (exp_head !== pixel_word) begin
            $display("ERROR %0s: expected %h, actual %h", test_name, exp_head, pixel_word);
            note_error();
          end
        end
      end
      // Window end seen, meter read the count from before that edge
      if (rate_pulse !== pulse_seen) begin
        rate_sum     = rate_sum + frame_rate;
        fc_at_toggle = fc_prev;
        pulse_seen   = rate_pulse;
        toggles++;
      end
      fc_prev = frame_count;

      if (test_end) begin
        if (exp_q.size() != 0) begin
          $display("Test %0s ended with %0d words never produced", test_name, exp_q.size());
          note_error();
        end
        if (frame_count - fc_mark != frame_count_t'(test_enabled)) begin
          $display("ERROR %0s frame_count: expected %0d, actual %0d", test_name,
                   fc_mark + frame_count_t'(test_enabled), frame_count);
          note_error();
        end
        fc_mark = frame_count;
        exp_q.delete();
        tests_run++;
        if (test_errors != 0) begin
          tests_failed++;
          $display("%0s: failed, %0d errors", test_name, test_errors);
        end else begin
          $display("%0s: passed", test_name);
        end
        test_errors = 0;
      end

      if (final_check) begin
        if (frame_count != enabled_frames) begin
          $display("ERROR final_frame_count: expected %0d, actual %0d",
                   enabled_frames, frame_count);
          note_error();
        end
        if (toggles < 2) begin
          $display("Rate pulse toggled only %0d times during the run", toggles);
          note_error();
        end
        // Windows sum up, tail frames after the last window end
        if (rate_sum + (frame_count - fc_at_toggle) != frame_count) begin
          $display("ERROR rate_sum: expected %0d, actual %0d",
                   frame_count, rate_sum + (frame_count - fc_at_toggle));
          note_error();
        end
        if (frame_rate != '0) begin
          $display("ERROR idle_frame_rate: expected 0, actual %0d", frame_rate);
          note_error();
        end
        $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed,
                 error_count);
        report_done = 1'b1;
      end
    end
    pending = exp_q.size();
  end

endmodule

`default_nettype wire

// ==== tb_camera_pipeline.sv ====
// ====================
// Testbench top for the pixel path
// Clock, reset, file reading, stimulus, timeout
// ====================
`timescale 1ns/10ps
`default_nettype none

`include "camera_cfg.svh"

module tb_camera_pipeline;
  import camera_pkg::*;
  import pixel_pkg::*;

  localparam int MAX_TESTS = 8;
  localparam int SAMPLES   = 16;   // 4x4 frame
  localparam int WORDS     = 4;    // One word per quad

  logic         ccd_pixel_clk, reset;
  raw_sample_t  sensor_data;
  logic         frame_valid, line_valid, capture_enable, rgb_mode;
  coord_t       frame_width, frame_height;
  buffer_word_t pixel_word;
  logic         word_valid, rate_pulse;
  frame_count_t frame_count, frame_rate;

  // Checker side
  logic         exp_push, test_end, test_enabled, final_check, report_done;
  buffer_word_t exp_word;
  logic [127:0] test_name;
  frame_count_t enabled_frames;
  int           pending, error_count;

  // Test table from the file
  logic [127:0] names[MAX_TESTS];
  raw_sample_t  raw[MAX_TESTS][SAMPLES];
  buffer_word_t expw[MAX_TESTS][WORDS];
  logic         mode_a[MAX_TESTS], en_a[MAX_TESTS];
  coord_t       w_a[MAX_TESTS], h_a[MAX_TESTS];
  int           n_tests, parse_errors;

  integer       seed = 32'hca38_bdbe;
  int           cycle_count, cycle_limit;

  always #4 ccd_pixel_clk = ~ccd_pixel_clk;   // 8 ns period

  camera_pipeline_top u_dut (
    .ccd_pixel_clk (ccd_pixel_clk),
    .reset         (reset),
    .sensor_data   (sensor_data),
    .frame_valid   (frame_valid),
    .line_valid    (line_valid),
    .capture_enable(capture_enable),
    .frame_width   (frame_width),
    .frame_height  (frame_height),
    .rgb_mode      (rgb_mode),
    .pixel_word    (pixel_word),
    .word_valid    (word_valid),
    .frame_count   (frame_count),
    .frame_rate    (frame_rate),
    .rate_pulse    (rate_pulse)
  );

  tb_checker u_checker (
    .ccd_pixel_clk (ccd_pixel_clk),
    .reset         (reset),
    .word_valid    (word_valid),
    .pixel_word    (pixel_word),
    .frame_count   (frame_count),
    .frame_rate    (frame_rate),
    .rate_pulse    (rate_pulse),
    .exp_push      (exp_push),
    .exp_word      (exp_word),
    .test_end      (test_end),
    .test_enabled  (test_enabled),
    .test_name     (test_name),
    .final_check   (final_check),
    .enabled_frames(enabled_frames),
    .pending       (pending),
    .error_count   (error_count),
    .report_done   (report_done)
  );

  // ====================
  // Timeout
  // ====================
  always @(posedge ccd_pixel_clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
      $display("Timeout after %0d cycles, DUT or checker stalled", cycle_count);
      $display("Test FAILED");
      $finish;
    end
  end

  // Parse the stimulus file, one test per line
  task automatic read_tests();
    int    fd, cnt;
    int    md, ce, fw, fh;
    int    s[SAMPLES];
    int    e[WORDS];
    string line;
    logic [127:0] nm;
    fd = $fopen("stream_input.txt", "r");
    if (fd == 0) begin
      $display("Cannot open stream_input.txt");
      parse_errors++;
      return;
    end
    while (!$feof(fd) && n_tests < MAX_TESTS) begin
      line = "";
      cnt  = $fgets(line, fd);
      if (line.len() < 2 || line[0] == "#")
        continue;                                     // Comment or blank
      cnt = $sscanf(line,
                    "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                    nm, md, ce, fw, fh, s[0], s[1], s[2], s[3], s[4], s[5], s[6], s[7],
                    s[8], s[9], s[10], s[11], s[12], s[13], s[14], s[15],
                    e[0], e[1], e[2], e[3]);
      if (cnt != 25) begin
        $display("Malformed line in stream_input.txt, %0d fields", cnt);
        parse_errors++;
        continue;
      end
      names[n_tests]  = nm;
      mode_a[n_tests] = md[0];
      en_a[n_tests]   = ce[0];
      w_a[n_tests]    = coord_t'(fw);
      h_a[n_tests]    = coord_t'(fh);
      for (int k = 0; k < SAMPLES; k++)
        raw[n_tests][k] = raw_sample_t'(s[k]);
      for (int k = 0; k < WORDS; k++)
        expw[n_tests][k] = buffer_word_t'(e[k]);
      n_tests++;
    end
    $fclose(fd);
  endtask

  // One sensor frame with random gaps, then drain
  task automatic run_frame(input int t);
    @(posedge ccd_pixel_clk);
    rgb_mode       <= mode_a[t];                      // Only between frames
    capture_enable <= en_a[t];
    frame_width    <= w_a[t];
    frame_height   <= h_a[t];
    test_name      <= names[t];
    if (en_a[t]) begin
      for (int k = 0; k < WORDS; k++) begin
        @(posedge ccd_pixel_clk);
        exp_push <= 1'b1;
        exp_word <= expw[t][k];
      end
    end
    @(posedge ccd_pixel_clk);
    exp_push    <= 1'b0;
    frame_valid <= 1'b1;
    for (int r = 0; r < int'(h_a[t]); r++) begin
      for (int c = 0; c < int'(w_a[t]); c++) begin
        if (($random(seed) & 3) == 0) begin           // Idle gap inside the line
          @(posedge ccd_pixel_clk);
          line_valid <= 1'b0;
        end
        @(posedge ccd_pixel_clk);
        line_valid  <= 1'b1;
        sensor_data <= raw[t][r * int'(w_a[t]) + c];
      end
      repeat (2) begin                                // Line blanking
        @(posedge ccd_pixel_clk);
        line_valid <= 1'b0;
      end
    end
    @(posedge ccd_pixel_clk);
    frame_valid <= 1'b0;
    @(posedge ccd_pixel_clk);
    while (pending != 0)
      @(posedge ccd_pixel_clk);
    repeat (8) @(posedge ccd_pixel_clk);               // frame_count settles
    test_enabled <= en_a[t];
    test_end     <= 1'b1;
    @(posedge ccd_pixel_clk);
    test_end     <= 1'b0;
  endtask

  // ====================
  // Main sequence
  // ====================
  initial begin
    ccd_pixel_clk  = 1'b0;
    reset          = 1'b1;
    sensor_data    = '0;
    frame_valid    = 1'b0;
    line_valid     = 1'b0;
    capture_enable = 1'b0;
    rgb_mode       = 1'b1;
    frame_width    = coord_t'(4);
    frame_height   = coord_t'(4);
    exp_push       = 1'b0;
    exp_word       = '0;
    test_end       = 1'b0;
    test_enabled   = 1'b0;
    test_name      = '0;
    final_check    = 1'b0;
    enabled_frames = '0;
    n_tests        = 0;
    parse_errors   = 0;
    cycle_count    = 0;
    cycle_limit    = 0;
    read_tests();
    for (int t = 0; t < n_tests; t++)
      enabled_frames = enabled_frames + frame_count_t'(en_a[t]);
    cycle_limit = 4 * n_tests * SAMPLES + 3 * `RATE_WINDOW_CYCLES;
    repeat (2) @(posedge ccd_pixel_clk);
    reset <= 1'b0;
    for (int t = 0; t < n_tests; t++)
      run_frame(t);
    repeat (2 * `RATE_WINDOW_CYCLES + 8) @(posedge ccd_pixel_clk);   // Idle windows
    final_check <= 1'b1;
    @(posedge ccd_pixel_clk);
    final_check <= 1'b0;
    while (!report_done)
      @(posedge ccd_pixel_clk);
    if (n_tests == 0)
      $display("No tests read from the stimulus file");
    if (error_count == 0 && parse_errors == 0 && n_tests != 0)
      $display("Test OK");
    else
      $display("Test FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== stream_input.txt ====
# name mode(1=rgb) capture_enable width height, 16 raw samples in raster order (hex),
# then 4 expected buffer words (hex, ignored when capture_enable is 0)
rgb_basic 1 1 4 4 080 F80 200 000 100 080 F80 400 FFF FFF 001 800 FFF FFF 400 002 7C22 00DF 7FFF 4008
hue_sect 0 1 4 4 800 800 640 C80 800 800 320 640 DC0 140 3C0 B40 780 DC0 F00 3C0 0000 000E 006A 00C7
hue_ties 0 1 4 4 C80 C80 320 C80 640 C80 640 320 960 0A0 640 140 960 960 FA0 640 002B 00F2 0080 009D
gated 1 0 4 4 080 F80 200 000 100 080 F80 400 FFF FFF 001 800 FFF FFF 400 002 0000 0000 0000 0000
rgb_sect 1 1 4 4 800 800 640 C80 800 800 320 640 DC0 140 3C0 B40 780 DC0 F00 3C0 4210 6586 0B6F 58FE

// ==== list.f ====
+incdir+.
camera_pkg.sv
pixel_pkg.sv
ccd_capture.sv
bayer_demosaic.sv
rgb_to_hue.sv
pixel_packer.sv
frame_rate_meter.sv
camera_pipeline_top.sv
tb_checker.sv
tb_camera_pipeline.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the pixel path testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary -Wno-fatal -f list.f --top-module tb_camera_pipeline -o sim_camera
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_camera > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Test FAILED" "$LOG"; then
  echo "Simulation reported failure"
  exit 1
fi

if ! grep -q "Test OK" "$LOG"; then
  echo "Simulation ended without a result line"
  exit 1
fi

exit 0
